// ==== logic/mempool_pkg.sv ====
// Cluster-wide definitions
`default_nettype none

package mempool_pkg;

  // Fixed cluster size
  localparam int unsigned NumGroups = 4;

  typedef logic [1:0] group_id_t;

  localparam int unsigned DataWidth = 32;

  typedef logic [DataWidth-1:0]   data_t;
  typedef logic [DataWidth/8-1:0] strb_t;
  typedef logic [31:0]            addr_t;

  // Word index starts right above the byte offset
  localparam int unsigned ByteOffset = 2;

  // Link direction, target group xor own group
  typedef enum logic [1:0] {
    DirLocal     = 2'd0,
    DirEast      = 2'd1,
    DirNorth     = 2'd2,
    DirNortheast = 2'd3
  } dir_e;

  // Request payload: wdata, wen, be, word index, initiator, tag
  function automatic int unsigned req_width(int unsigned idx_width, int unsigned tag_width);
    return DataWidth + 1 + DataWidth / 8 + idx_width + $bits(group_id_t) + tag_width;
  endfunction

  // Response payload: rdata, initiator, tag
  function automatic int unsigned resp_width(int unsigned tag_width);
    return DataWidth + $bits(group_id_t) + tag_width;
  endfunction

endpackage : mempool_pkg

`default_nettype wire

// ==== logic/spill_register.sv ====
// Two-entry register cut
`default_nettype none

module spill_register #(
  parameter type T = logic
) (
  input  logic clk_i,
  input  logic reset_i,
  input  logic valid_i,
  output logic ready_o,
  input  T     data_i,
  output logic valid_o,
  input  logic ready_i,
  output T     data_o
);

  T           mem_q [2];
  logic       wr_ptr_q;
  logic       rd_ptr_q;
  logic [1:0] count_q;
  logic       push;
  logic       pop;

  // Both handshake outputs come from the fill counter only
  assign ready_o = (count_q != 2'd2);
  assign valid_o = (count_q != 2'd0);
  assign data_o  = mem_q[rd_ptr_q];
  assign push    = valid_i & ready_o;
  assign pop     = valid_o & ready_i;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      wr_ptr_q <= 1'b0;
      rd_ptr_q <= 1'b0;
      count_q  <= 2'd0;
    end else begin
      if (push) begin
        wr_ptr_q <= ~wr_ptr_q;
      end
      if (pop) begin
        rd_ptr_q <= ~rd_ptr_q;
      end
      count_q <= count_q + 2'(push) - 2'(pop);
    end
  end

  always_ff @(posedge clk_i) begin
    if (push) begin
      mem_q[wr_ptr_q] <= data_i;
    end
  end

endmodule : spill_register

`default_nettype wire

// ==== logic/tcdm_rr_arbiter.sv ====
// Four-way round-robin arbiter
`default_nettype none

module tcdm_rr_arbiter #(
  parameter type T = logic
) (
  input  logic       clk_i,
  input  logic       reset_i,
  input  logic [3:0] in_valid_i,
  input  T     [3:0] in_data_i,
  output logic [3:0] in_ready_o,
  output logic       out_valid_o,
  output T           out_data_o,
  input  logic       out_ready_i
);

  logic [1:0] last_q;
  logic [1:0] lock_idx_q;
  logic       lock_q;
  logic [1:0] sel;
  logic [1:0] cand;

  // Nearest valid input after the last grant wins
  always_comb begin
    sel  = lock_idx_q;
    cand = last_q;
    if (!lock_q) begin
      sel = last_q;
      for (int i = 4; i >= 1; i--) begin
        cand = last_q + 2'(i);
        if (in_valid_i[cand]) begin
          sel = cand;
        end
      end
    end
  end

  assign out_valid_o = in_valid_i[sel];
  assign out_data_o  = in_data_i[sel];
  assign in_ready_o  = {4{out_valid_o & out_ready_i}} & (4'b0001 << sel);

  // Grant stays put while the output is stalled
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      last_q     <= 2'd3;
      lock_idx_q <= 2'd0;
      lock_q     <= 1'b0;
    end else if (out_valid_o && !out_ready_i) begin
      lock_q     <= 1'b1;
      lock_idx_q <= sel;
    end else if (out_valid_o) begin
      lock_q <= 1'b0;
      last_q <= sel;
    end
  end

endmodule : tcdm_rr_arbiter

`default_nettype wire

// ==== logic/tcdm_bank.sv ====
// Byte-enabled memory bank
`default_nettype none

module tcdm_bank #(
  parameter  int unsigned BankWords = 256,
  parameter  int unsigned TagWidth  = 4,
  localparam int unsigned IdxWidth  = $clog2(BankWords),
  localparam int unsigned MetaWidth = $bits(mempool_pkg::group_id_t) + TagWidth
) (
  input  logic                 clk_i,
  input  logic                 reset_i,
  input  logic                 req_valid_i,
  output logic                 req_ready_o,
  input  logic                 req_wen_i,
  input  mempool_pkg::strb_t   req_be_i,
  input  mempool_pkg::data_t   req_wdata_i,
  input  logic [IdxWidth-1:0]  req_idx_i,
  input  logic [MetaWidth-1:0] req_meta_i,
  output logic                 resp_valid_o,
  input  logic                 resp_ready_i,
  output mempool_pkg::data_t   resp_rdata_o,
  output logic [MetaWidth-1:0] resp_meta_o
);
  import mempool_pkg::*;

  data_t                mem_q [BankWords];
  data_t                word_new;
  logic                 req_fire;
  logic                 resp_valid_q;
  data_t                rdata_q;
  logic [MetaWidth-1:0] meta_q;

  // Accept only when the response slot frees up
  assign req_ready_o = ~resp_valid_q | resp_ready_i;
  assign req_fire    = req_valid_i & req_ready_o;

  // Stored word with the enabled bytes replaced on a write
  always_comb begin
    word_new = mem_q[req_idx_i];
    for (int b = 0; b < DataWidth / 8; b++) begin
      if (req_wen_i && req_be_i[b]) begin
        word_new[8*b +: 8] = req_wdata_i[8*b +: 8];
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (req_fire && req_wen_i) begin
      mem_q[req_idx_i] <= word_new;
    end
    if (req_fire) begin
      rdata_q <= word_new;
      meta_q  <= req_meta_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      resp_valid_q <= 1'b0;
    end else if (req_fire) begin
      resp_valid_q <= 1'b1;
    end else if (resp_ready_i) begin
      resp_valid_q <= 1'b0;
    end
  end

  assign resp_valid_o = resp_valid_q;
  assign resp_rdata_o = rdata_q;
  assign resp_meta_o  = meta_q;

endmodule : tcdm_bank

`default_nettype wire

// ==== logic/mempool_group.sv ====
// MemPool group with one bank
`default_nettype none

module mempool_group #(
  parameter  int unsigned BankWords = 256,
  parameter  int unsigned TagWidth  = 4,
  localparam int unsigned IdxWidth  = $clog2(BankWords),
  localparam int unsigned ReqWidth  = mempool_pkg::req_width(IdxWidth, TagWidth),
  localparam int unsigned RespWidth = mempool_pkg::resp_width(TagWidth)
) (
  input  logic                       clk_i,
  input  logic                       reset_i,
  input  mempool_pkg::group_id_t     group_id_i,
  // Core port
  input  logic                       req_valid_i,
  output logic                       req_ready_o,
  input  mempool_pkg::addr_t         req_addr_i,
  input  logic                       req_wen_i,
  input  mempool_pkg::strb_t         req_be_i,
  input  mempool_pkg::data_t         req_wdata_i,
  input  logic [TagWidth-1:0]        req_tag_i,
  output logic                       resp_valid_o,
  input  logic                       resp_ready_i,
  output mempool_pkg::data_t         resp_rdata_o,
  output logic [TagWidth-1:0]        resp_tag_o,
  // Links indexed by direction code, 1 east, 2 north, 3 northeast
  output logic [3:1]                 master_req_valid_o,
  input  logic [3:1]                 master_req_ready_i,
  output logic [3:1][ReqWidth-1:0]   master_req_o,
  input  logic [3:1]                 master_resp_valid_i,
  output logic [3:1]                 master_resp_ready_o,
  input  logic [3:1][RespWidth-1:0]  master_resp_i,
  input  logic [3:1]                 slave_req_valid_i,
  output logic [3:1]                 slave_req_ready_o,
  input  logic [3:1][ReqWidth-1:0]   slave_req_i,
  output logic [3:1]                 slave_resp_valid_o,
  input  logic [3:1]                 slave_resp_ready_i,
  output logic [3:1][RespWidth-1:0]  slave_resp_o
);
  import mempool_pkg::*;

  localparam int unsigned MetaWidth = $bits(group_id_t) + TagWidth;

  typedef struct packed {
    data_t                wdata;
    logic                 wen;
    strb_t                be;
    logic [IdxWidth-1:0]  idx;
    group_id_t            ini;
    logic [TagWidth-1:0]  tag;
  } req_t;

  typedef struct packed {
    data_t                rdata;
    group_id_t            ini;
    logic [TagWidth-1:0]  tag;
  } resp_t;

  logic                 active_q;
  logic                 core_valid;
  req_t                 core_req;
  dir_e                 req_dir;
  logic [3:1]           out_ready;
  logic [3:0]           bank_in_valid;
  logic [3:0]           bank_in_ready;
  req_t [3:0]           bank_in_data;
  logic                 bank_req_valid;
  logic                 bank_req_ready;
  req_t                 bank_req;
  logic                 bank_resp_valid;
  logic                 bank_resp_ready;
  data_t                bank_rdata;
  logic [MetaWidth-1:0] bank_meta;
  resp_t                bank_resp;
  dir_e                 resp_dir;
  logic [3:1]           ret_ready;
  logic [3:0]           resp_in_valid;
  logic [3:0]           resp_in_ready;
  resp_t [3:0]          resp_in_data;
  resp_t                core_resp;

  // Core port opens one cycle after reset
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      active_q <= 1'b0;
    end else begin
      active_q <= 1'b1;
    end
  end

  // Request routing on the group bits of the address
  assign core_valid = req_valid_i & active_q;
  assign core_req   = '{wdata: req_wdata_i, wen: req_wen_i, be: req_be_i,
                        idx: req_addr_i[ByteOffset +: IdxWidth],
                        ini: group_id_i, tag: req_tag_i};
  assign req_dir    = dir_e'(req_addr_i[ByteOffset+IdxWidth +: $bits(group_id_t)] ^ group_id_i);
  assign req_ready_o = active_q &
                       ((req_dir == DirLocal) ? bank_in_ready[0] : out_ready[req_dir]);

  // Bank side, local request on input 0
  assign bank_in_valid     = {slave_req_valid_i, core_valid & (req_dir == DirLocal)};
  assign bank_in_data      = {slave_req_i, core_req};
  assign slave_req_ready_o = bank_in_ready[3:1];

  tcdm_rr_arbiter #(.T(req_t)) i_bank_arb (
    .clk_i,
    .reset_i,
    .in_valid_i  (bank_in_valid),
    .in_data_i   (bank_in_data),
    .in_ready_o  (bank_in_ready),
    .out_valid_o (bank_req_valid),
    .out_data_o  (bank_req),
    .out_ready_i (bank_req_ready)
  );

  tcdm_bank #(.BankWords(BankWords), .TagWidth(TagWidth)) i_bank (
    .clk_i,
    .reset_i,
    .req_valid_i  (bank_req_valid),
    .req_ready_o  (bank_req_ready),
    .req_wen_i    (bank_req.wen),
    .req_be_i     (bank_req.be),
    .req_wdata_i  (bank_req.wdata),
    .req_idx_i    (bank_req.idx),
    .req_meta_i   ({bank_req.ini, bank_req.tag}),
    .resp_valid_o (bank_resp_valid),
    .resp_ready_i (bank_resp_ready),
    .resp_rdata_o (bank_rdata),
    .resp_meta_o  (bank_meta)
  );

  // Responses go back the way the request came
  assign bank_resp       = {bank_rdata, bank_meta};
  assign resp_dir        = dir_e'(bank_resp.ini ^ group_id_i);
  assign bank_resp_ready = (resp_dir == DirLocal) ? resp_in_ready[0] : ret_ready[resp_dir];

  for (genvar d = 1; d < 4; d++) begin : gen_links
    spill_register #(.T(req_t)) i_req_spill (
      .clk_i,
      .reset_i,
      .valid_i (core_valid & (req_dir == dir_e'(d))),
      .ready_o (out_ready[d]),
      .data_i  (core_req),
      .valid_o (master_req_valid_o[d]),
      .ready_i (master_req_ready_i[d]),
      .data_o  (master_req_o[d])
    );

    spill_register #(.T(resp_t)) i_resp_spill (
      .clk_i,
      .reset_i,
      .valid_i (bank_resp_valid & (resp_dir == dir_e'(d))),
      .ready_o (ret_ready[d]),
      .data_i  (bank_resp),
      .valid_o (slave_resp_valid_o[d]),
      .ready_i (slave_resp_ready_i[d]),
      .data_o  (slave_resp_o[d])
    );
  end : gen_links

  // Core response merge, local bank on input 0
  assign resp_in_valid       = {master_resp_valid_i, bank_resp_valid & (resp_dir == DirLocal)};
  assign resp_in_data        = {master_resp_i, bank_resp};
  assign master_resp_ready_o = resp_in_ready[3:1];

  tcdm_rr_arbiter #(.T(resp_t)) i_resp_arb (
    .clk_i,
    .reset_i,
    .in_valid_i  (resp_in_valid),
    .in_data_i   (resp_in_data),
    .in_ready_o  (resp_in_ready),
    .out_valid_o (resp_valid_o),
    .out_data_o  (core_resp),
    .out_ready_i (resp_ready_i)
  );

  assign resp_rdata_o = core_resp.rdata;
  assign resp_tag_o   = core_resp.tag;

endmodule : mempool_group

`default_nettype wire

// ==== logic/mempool.sv ====
// Four-group MemPool cluster
`default_nettype none

module mempool #(
  parameter int unsigned BankWords = 256,
  parameter int unsigned TagWidth  = 4
) (
  input  logic                                                clk_i,
  input  logic                                                reset_i,
  input  logic               [mempool_pkg::NumGroups-1:0]                req_valid_i,
  output logic               [mempool_pkg::NumGroups-1:0]                req_ready_o,
  input  mempool_pkg::addr_t [mempool_pkg::NumGroups-1:0]                req_addr_i,
  input  logic               [mempool_pkg::NumGroups-1:0]                req_wen_i,
  input  mempool_pkg::strb_t [mempool_pkg::NumGroups-1:0]                req_be_i,
  input  mempool_pkg::data_t [mempool_pkg::NumGroups-1:0]                req_wdata_i,
  input  logic               [mempool_pkg::NumGroups-1:0][TagWidth-1:0]  req_tag_i,
  output logic               [mempool_pkg::NumGroups-1:0]                resp_valid_o,
  input  logic               [mempool_pkg::NumGroups-1:0]                resp_ready_i,
  output mempool_pkg::data_t [mempool_pkg::NumGroups-1:0]                resp_rdata_o,
  output logic               [mempool_pkg::NumGroups-1:0][TagWidth-1:0]  resp_tag_o
);
  import mempool_pkg::*;

  localparam int unsigned IdxWidth  = $clog2(BankWords);
  localparam int unsigned ReqWidth  = req_width(IdxWidth, TagWidth);
  localparam int unsigned RespWidth = resp_width(TagWidth);

  // Link channels per group, second index is the direction code
  logic [NumGroups-1:0][3:1]                master_req_valid;
  logic [NumGroups-1:0][3:1]                master_req_ready;
  logic [NumGroups-1:0][3:1][ReqWidth-1:0]  master_req;
  logic [NumGroups-1:0][3:1]                master_resp_valid;
  logic [NumGroups-1:0][3:1]                master_resp_ready;
  logic [NumGroups-1:0][3:1][RespWidth-1:0] master_resp;
  logic [NumGroups-1:0][3:1]                slave_req_valid;
  logic [NumGroups-1:0][3:1]                slave_req_ready;
  logic [NumGroups-1:0][3:1][ReqWidth-1:0]  slave_req;
  logic [NumGroups-1:0][3:1]                slave_resp_valid;
  logic [NumGroups-1:0][3:1]                slave_resp_ready;
  logic [NumGroups-1:0][3:1][RespWidth-1:0] slave_resp;

  for (genvar g = 0; g < NumGroups; g++) begin : gen_groups
    mempool_group #(
      .BankWords (BankWords),
      .TagWidth  (TagWidth)
    ) i_group (
      .clk_i,
      .reset_i,
      .group_id_i          (group_id_t'(g)),
      .req_valid_i         (req_valid_i[g]),
      .req_ready_o         (req_ready_o[g]),
      .req_addr_i          (req_addr_i[g]),
      .req_wen_i           (req_wen_i[g]),
      .req_be_i            (req_be_i[g]),
      .req_wdata_i         (req_wdata_i[g]),
      .req_tag_i           (req_tag_i[g]),
      .resp_valid_o        (resp_valid_o[g]),
      .resp_ready_i        (resp_ready_i[g]),
      .resp_rdata_o        (resp_rdata_o[g]),
      .resp_tag_o          (resp_tag_o[g]),
      .master_req_valid_o  (master_req_valid[g]),
      .master_req_ready_i  (master_req_ready[g]),
      .master_req_o        (master_req[g]),
      .master_resp_valid_i (master_resp_valid[g]),
      .master_resp_ready_o (master_resp_ready[g]),
      .master_resp_i       (master_resp[g]),
      .slave_req_valid_i   (slave_req_valid[g]),
      .slave_req_ready_o   (slave_req_ready[g]),
      .slave_req_i         (slave_req[g]),
      .slave_resp_valid_o  (slave_resp_valid[g]),
      .slave_resp_ready_i  (slave_resp_ready[g]),
      .slave_resp_o        (slave_resp[g])
    );
  end : gen_groups

  // East pairs g with g^1, north with g^2, northeast with g^3
  for (genvar ini = 0; ini < NumGroups; ini++) begin : gen_interconnect
    for (genvar d = 1; d < 4; d++) begin : gen_dir
      assign slave_req[ini ^ d][d]         = master_req[ini][d];
      assign slave_req_valid[ini ^ d][d]   = master_req_valid[ini][d];
      assign master_req_ready[ini][d]      = slave_req_ready[ini ^ d][d];
      assign master_resp[ini ^ d][d]       = slave_resp[ini][d];
      assign master_resp_valid[ini ^ d][d] = slave_resp_valid[ini][d];
      assign slave_resp_ready[ini][d]      = master_resp_ready[ini ^ d][d];
    end : gen_dir
  end : gen_interconnect

  if (BankWords < 2 || BankWords != 2**IdxWidth)
    $fatal(1, "[mempool] BankWords must be a power of two, at least 2.");

  if (TagWidth < 1)
    $fatal(1, "[mempool] TagWidth must be at least 1.");

  if (ByteOffset + IdxWidth + $bits(group_id_t) > $bits(addr_t))
    $fatal(1, "[mempool] Bank and group fields do not fit the address.");

endmodule : mempool

`default_nettype wire

// ==== test/mempool_assertions.sv ====
// Group handshake assertions
`default_nettype none

module mempool_assertions #(
  parameter int unsigned TagWidth = 4
) (
  input logic                clk_i,
  input logic                reset_i,
  input logic                req_ready_i,
  input logic                resp_valid_i,
  input logic                resp_ready_i,
  input mempool_pkg::data_t  resp_rdata_i,
  input logic [TagWidth-1:0] resp_tag_i
);

  int fail_count = 0;

  // A stalled response stays valid
  a_resp_held: assert property (@(posedge clk_i) disable iff (reset_i)
    resp_valid_i && !resp_ready_i |=> resp_valid_i)
  else begin
    $error("Response valid dropped before ready");
    fail_count++;
  end

  // Payload frozen while stalled
  a_resp_stable: assert property (@(posedge clk_i) disable iff (reset_i)
    resp_valid_i && !resp_ready_i |=> $stable(resp_rdata_i) && $stable(resp_tag_i))
  else begin
    $error("Response payload changed while stalled");
    fail_count++;
  end

  a_ready_in_reset: assert property (@(posedge clk_i) reset_i |=> !req_ready_i)
  else begin
    $error("Request ready high right after a reset cycle");
    fail_count++;
  end

endmodule : mempool_assertions

bind mempool_group mempool_assertions #(.TagWidth(TagWidth)) i_assertions (
  .clk_i        (clk_i),
  .reset_i      (reset_i),
  .req_ready_i  (req_ready_o),
  .resp_valid_i (resp_valid_o),
  .resp_ready_i (resp_ready_i),
  .resp_rdata_i (resp_rdata_o),
  .resp_tag_i   (resp_tag_o)
);

`default_nettype wire

// ==== test/mempool_checker.sv ====
// Response checker with memory model
`default_nettype none

module mempool_checker #(
  parameter  int unsigned BankWords = 256,
  parameter  int unsigned TagWidth  = 4,
  localparam int unsigned SlotBits  = $clog2(BankWords) + $bits(mempool_pkg::group_id_t),
  localparam int unsigned NumTags   = 2**TagWidth
) (
  input  logic                                                      clk_i,
  input  logic                                                      reset_i,
  input  logic               [mempool_pkg::NumGroups-1:0]               req_valid_i,
  input  logic               [mempool_pkg::NumGroups-1:0]               req_ready_i,
  input  mempool_pkg::addr_t [mempool_pkg::NumGroups-1:0]               req_addr_i,
  input  logic               [mempool_pkg::NumGroups-1:0]               req_wen_i,
  input  mempool_pkg::strb_t [mempool_pkg::NumGroups-1:0]               req_be_i,
  input  mempool_pkg::data_t [mempool_pkg::NumGroups-1:0]               req_wdata_i,
  input  logic               [mempool_pkg::NumGroups-1:0][TagWidth-1:0] req_tag_i,
  input  logic               [mempool_pkg::NumGroups-1:0][127:0]        req_name_i,
  input  mempool_pkg::data_t [mempool_pkg::NumGroups-1:0]               req_exp_i,
  input  logic               [mempool_pkg::NumGroups-1:0]               resp_valid_i,
  input  logic               [mempool_pkg::NumGroups-1:0]               resp_ready_i,
  input  mempool_pkg::data_t [mempool_pkg::NumGroups-1:0]               resp_rdata_i,
  input  logic               [mempool_pkg::NumGroups-1:0][TagWidth-1:0] resp_tag_i,
  output int                                                        pending_o,
  output int                                                        done_o,
  output int                                                        errors_o
);
  import mempool_pkg::*;

  // Whole cluster memory indexed by group and word
  data_t        model [NumGroups*BankWords];
  logic         busy_q [NumGroups][NumTags];
  logic [127:0] name_q [NumGroups][NumTags];
  data_t        exp_q [NumGroups][NumTags];

  task automatic record_request(input int g);
    int unsigned slot;
    int          t;
    data_t       word;
    slot = int'(req_addr_i[g][ByteOffset +: SlotBits]);
    t    = int'(req_tag_i[g]);
    word = model[slot];
    for (int b = 0; b < DataWidth / 8; b++) begin
      if (req_wen_i[g] && req_be_i[g][b]) begin
        word[8*b +: 8] = req_wdata_i[g][8*b +: 8];
      end
    end
    if (req_wen_i[g]) begin
      model[slot] = word;
    end
    if (word !== req_exp_i[g]) begin
      $display("Table entry %0s disagrees with the memory model: table 0x%08h, model 0x%08h",
               req_name_i[g], req_exp_i[g], word);
      errors_o++;
    end
    if (busy_q[g][t]) begin
      $display("Group %0d issued tag %0d again while it was still outstanding", g, t);
      errors_o++;
    end else begin
      pending_o++;
    end
    busy_q[g][t] = 1'b1;
    name_q[g][t] = req_name_i[g];
    exp_q[g][t]  = word;
  endtask

  task automatic check_response(input int g);
    int t;
    t = int'(resp_tag_i[g]);
    if (!busy_q[g][t]) begin
      $display("Group %0d received a response with tag %0d that nobody is waiting for", g, t);
      errors_o++;
    end else begin
      busy_q[g][t] = 1'b0;
      pending_o--;
      done_o++;
      if (resp_rdata_i[g] !== exp_q[g][t]) begin
        $display("Error: %0s group %0d tag %0d expected 0x%08h actual 0x%08h",
                 name_q[g][t], g, t, exp_q[g][t], resp_rdata_i[g]);
        errors_o++;
      end else begin
        $display("Done: %0s group %0d tag %0d data 0x%08h", name_q[g][t], g, t, resp_rdata_i[g]);
      end
    end
  endtask

  // Handshakes are stable at the falling edge
  always @(negedge clk_i) begin
    if (reset_i) begin
      pending_o = 0;
      done_o    = 0;
      errors_o  = 0;
      for (int g = 0; g < NumGroups; g++) begin
        for (int t = 0; t < NumTags; t++) begin
          busy_q[g][t] = 1'b0;
        end
      end
    end else begin
      for (int g = 0; g < NumGroups; g++) begin
        if (resp_valid_i[g] && resp_ready_i[g]) begin
          check_response(g);
        end
        if (req_valid_i[g] && req_ready_i[g]) begin
          record_request(g);
        end
      end
    end
  end

endmodule : mempool_checker

`default_nettype wire

// ==== test/tb_mempool.sv ====
// MemPool cluster testbench
`default_nettype none

module tb_mempool;
  import mempool_pkg::*;

  localparam int unsigned BankWords  = 256;
  localparam int unsigned TagWidth   = 4;
  localparam int unsigned IdxWidth   = $clog2(BankWords);
  localparam int          DriveDelay = 5;
  localparam int          MaxEntries = 96;

  logic                                clk;
  logic                                reset;
  logic [NumGroups-1:0]                req_valid;
  logic [NumGroups-1:0]                req_ready;
  addr_t [NumGroups-1:0]               req_addr;
  logic [NumGroups-1:0]                req_wen;
  strb_t [NumGroups-1:0]               req_be;
  data_t [NumGroups-1:0]               req_wdata;
  logic [NumGroups-1:0][TagWidth-1:0]  req_tag;
  logic [NumGroups-1:0][127:0]         req_name;
  data_t [NumGroups-1:0]               req_exp;
  logic [NumGroups-1:0]                resp_valid;
  logic [NumGroups-1:0]                resp_ready;
  data_t [NumGroups-1:0]               resp_rdata;
  logic [NumGroups-1:0][TagWidth-1:0]  resp_tag;
  int                                  pending;
  int                                  done;
  int                                  chk_errors;
  int                                  tb_errors = 0;
  int                                  cycles = 0;
  integer                              seed = 32'h7b81d5c0;

  // Stimulus table
  logic [127:0]        tbl_name [MaxEntries];
  int                  tbl_group [MaxEntries];
  logic                tbl_wen [MaxEntries];
  addr_t               tbl_addr [MaxEntries];
  strb_t               tbl_be [MaxEntries];
  data_t               tbl_data [MaxEntries];
  logic [TagWidth-1:0] tbl_tag [MaxEntries];
  data_t               tbl_exp [MaxEntries];
  int                  n_entries = 0;

  mempool #(.BankWords(BankWords), .TagWidth(TagWidth)) i_mempool (
    .clk_i        (clk),
    .reset_i      (reset),
    .req_valid_i  (req_valid),
    .req_ready_o  (req_ready),
    .req_addr_i   (req_addr),
    .req_wen_i    (req_wen),
    .req_be_i     (req_be),
    .req_wdata_i  (req_wdata),
    .req_tag_i    (req_tag),
    .resp_valid_o (resp_valid),
    .resp_ready_i (resp_ready),
    .resp_rdata_o (resp_rdata),
    .resp_tag_o   (resp_tag)
  );

  mempool_checker #(.BankWords(BankWords), .TagWidth(TagWidth)) i_checker (
    .clk_i        (clk),
    .reset_i      (reset),
    .req_valid_i  (req_valid),
    .req_ready_i  (req_ready),
    .req_addr_i   (req_addr),
    .req_wen_i    (req_wen),
    .req_be_i     (req_be),
    .req_wdata_i  (req_wdata),
    .req_tag_i    (req_tag),
    .req_name_i   (req_name),
    .req_exp_i    (req_exp),
    .resp_valid_i (resp_valid),
    .resp_ready_i (resp_ready),
    .resp_rdata_i (resp_rdata),
    .resp_tag_i   (resp_tag),
    .pending_o    (pending),
    .done_o       (done),
    .errors_o     (chk_errors)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // Group bits sit right above the word index
  function automatic addr_t bank_addr(input int bank, input int idx);
    return (addr_t'(bank) << (ByteOffset + IdxWidth)) | (addr_t'(idx) << ByteOffset);
  endfunction

  function automatic int assertion_failures();
    return i_mempool.gen_groups[0].i_group.i_assertions.fail_count
         + i_mempool.gen_groups[1].i_group.i_assertions.fail_count
         + i_mempool.gen_groups[2].i_group.i_assertions.fail_count
         + i_mempool.gen_groups[3].i_group.i_assertions.fail_count;
  endfunction

  task automatic add_entry(input logic [127:0] name, input int g, input logic wen,
                           input addr_t addr, input strb_t be, input data_t data,
                           input int tag, input data_t exp);
    tbl_name[n_entries]  = name;
    tbl_group[n_entries] = g;
    tbl_wen[n_entries]   = wen;
    tbl_addr[n_entries]  = addr;
    tbl_be[n_entries]    = be;
    tbl_data[n_entries]  = data;
    tbl_tag[n_entries]   = TagWidth'(tag);
    tbl_exp[n_entries]   = exp;
    n_entries++;
  endtask

  // A write answers with the word as it stands after the write
  task automatic build_table();
    data_t w;
    add_entry("local_rw", 0, 1'b1, bank_addr(0, 5), 4'hf, 32'h1122_3344, 0, 32'h1122_3344);
    add_entry("local_rw", 0, 1'b0, bank_addr(0, 5), 4'h0, 32'h0, 1, 32'h1122_3344);
    add_entry("local_rw", 2, 1'b1, bank_addr(2, 9), 4'hf, 32'hA5A5_5A5A, 0, 32'hA5A5_5A5A);
    add_entry("local_rw", 2, 1'b0, bank_addr(2, 9), 4'h0, 32'h0, 1, 32'hA5A5_5A5A);
    // East, north and northeast from group 0
    for (int b = 1; b < 4; b++) begin
      w = 32'hE0E0_0000 | b;
      add_entry("remote_wr", 0, 1'b1, bank_addr(b, 16 + b), 4'hf, w, b, w);
    end
    for (int g = 0; g < 4; g++) begin
      for (int b = 1; b < 4; b++) begin
        add_entry("remote_rd", g, 1'b0, bank_addr(b, 16 + b), 4'h0, 32'h0, b, 32'hE0E0_0000 | b);
      end
    end
    add_entry("byte_en", 1, 1'b1, bank_addr(1, 32), 4'hf, 32'hDEAD_BEEF, 0, 32'hDEAD_BEEF);
    add_entry("byte_en", 1, 1'b1, bank_addr(1, 32), 4'b0001, 32'h0000_0055, 1, 32'hDEAD_BE55);
    add_entry("byte_en", 1, 1'b1, bank_addr(1, 32), 4'b1100, 32'h1234_0000, 2, 32'h1234_BE55);
    add_entry("byte_en", 1, 1'b0, bank_addr(1, 32), 4'h0, 32'h0, 3, 32'h1234_BE55);
    add_entry("byte_en", 3, 1'b1, bank_addr(0, 40), 4'hf, 32'h0102_0304, 0, 32'h0102_0304);
    add_entry("byte_en", 3, 1'b1, bank_addr(0, 40), 4'b0110, 32'hAABB_CCDD, 1, 32'h01BB_CC04);
    add_entry("byte_en", 3, 1'b0, bank_addr(0, 40), 4'h0, 32'h0, 2, 32'h01BB_CC04);
    // Everybody hammers bank 2
    for (int g = 0; g < 4; g++) begin
      for (int k = 0; k < 2; k++) begin
        w = 32'hC000_0000 | (g << 8) | k;
        add_entry("contention", g, 1'b1, bank_addr(2, 64 + 4 * g + k), 4'hf, w, k, w);
      end
    end
    for (int g = 0; g < 4; g++) begin
      for (int k = 0; k < 2; k++) begin
        w = 32'hC000_0000 | (g << 8) | k;
        add_entry("contention", g, 1'b0, bank_addr(2, 64 + 4 * g + k), 4'h0, 32'h0, 2 + k, w);
      end
    end
    for (int g = 0; g < 4; g++) begin
      for (int b = 0; b < 4; b++) begin
        w = 32'h6A00_0000 | (g << 16) | (b << 8) | (g ^ b);
        add_entry("mixed", g, 1'b1, bank_addr(b, 128 + g), 4'hf, w, b, w);
      end
    end
    for (int g = 0; g < 4; g++) begin
      for (int b = 0; b < 4; b++) begin
        w = 32'h6A00_0000 | (g << 16) | (b << 8) | (g ^ b);
        add_entry("mixed", g, 1'b0, bank_addr(b, 128 + g), 4'h0, 32'h0, 4 + b, w);
      end
    end
  endtask

  // Issues one group's entries of a section, each held until accepted
  task automatic drive_group(input int g, input int lo, input int hi);
    logic accepted;
    for (int i = lo; i <= hi; i++) begin
      if (tbl_group[i] == g) begin
        req_valid[g] = 1'b1;
        req_addr[g]  = tbl_addr[i];
        req_wen[g]   = tbl_wen[i];
        req_be[g]    = tbl_be[i];
        req_wdata[g] = tbl_data[i];
        req_tag[g]   = tbl_tag[i];
        req_name[g]  = tbl_name[i];
        req_exp[g]   = tbl_exp[i];
        accepted = 1'b0;
        while (!accepted) begin
          @(negedge clk);
          accepted = req_ready[g];
          @(posedge clk);
          #(DriveDelay);
        end
        req_valid[g] = 1'b0;
      end
    end
  endtask

  task automatic check_idle();
    if (req_ready !== '0 || resp_valid !== '0) begin
      $display("Error: reset_idle expected 0x0 actual ready 0x%h valid 0x%h",
               req_ready, resp_valid);
      tb_errors++;
    end else begin
      $display("Done: reset_idle ready and valid low");
    end
  endtask

  // Random back-pressure on every response port
  always @(posedge clk) begin
    #(DriveDelay);
    resp_ready = 4'($random(seed));
  end

  always @(posedge clk) begin
    cycles = cycles + 1;
    if (cycles >= n_entries * 40) begin
      $display("Timeout after %0d cycles with %0d responses still outstanding", cycles, pending);
      $display("Simulation finished: FAIL");
      $finish;
    end
  end

  initial begin
    int lo;
    int hi;
    reset      = 1'b1;
    req_valid  = '0;
    req_addr   = '0;
    req_wen    = '0;
    req_be     = '0;
    req_wdata  = '0;
    req_tag    = '0;
    req_name   = '0;
    req_exp    = '0;
    resp_ready = '0;
    build_table();
    @(posedge clk);
    @(negedge clk);
    check_idle();
    @(posedge clk);
    #(DriveDelay);
    reset = 1'b0;
    @(negedge clk);
    check_idle();
    @(posedge clk);
    #(DriveDelay);
    // One section per test name, drained before the next one starts
    lo = 0;
    while (lo < n_entries) begin
      hi = lo;
      while (hi + 1 < n_entries && tbl_name[hi + 1] == tbl_name[lo]) begin
        hi++;
      end
      fork
        drive_group(0, lo, hi);
        drive_group(1, lo, hi);
        drive_group(2, lo, hi);
        drive_group(3, lo, hi);
      join
      while (pending != 0) begin
        @(posedge clk);
        #(DriveDelay);
      end
      lo = hi + 1;
    end
    repeat (4) @(posedge clk);
    if (done != n_entries) begin
      $display("Only %0d of %0d requests received a response", done, n_entries);
      tb_errors++;
    end
    tb_errors = tb_errors + assertion_failures();
    $display("Summary: %0d requests, %0d responses, %0d errors",
             n_entries, done, tb_errors + chk_errors);
    if (tb_errors + chk_errors == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule : tb_mempool

`default_nettype wire

// ==== compile.f ====
logic/mempool_pkg.sv
logic/spill_register.sv
logic/tcdm_rr_arbiter.sv
logic/tcdm_bank.sv
logic/mempool_group.sv
logic/mempool.sv
test/mempool_assertions.sv
test/mempool_checker.sv
test/tb_mempool.sv

// ==== Bender.yml ====
package:
  name: mempool_cluster

sources:
  - files:
      - logic/mempool_pkg.sv
      - logic/spill_register.sv
      - logic/tcdm_rr_arbiter.sv
      - logic/tcdm_bank.sv
      - logic/mempool_group.sv
      - logic/mempool.sv
  - target: test
    files:
      - test/mempool_assertions.sv
      - test/mempool_checker.sv
      - test/tb_mempool.sv
